// ==== common/cpu_pkg.sv ====
/*
 * Shared definitions for the multicycle core
 *   Word, register file and address widths
 *   Opcode, ALU function and FSM state encodings
 *   Flag bit positions inside the flags byte
 *   Instruction word with its register, absolute and immediate views
 */
package cpu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int xlen       = 32;         // Data and address width
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc_default = 32'h0000_8000;

    // Flag bits sit in the low nibble
    localparam int flag_c = 0;
    localparam int flag_z = 1;
    localparam int flag_n = 2;
    localparam int flag_v = 3;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        op_add   = 6'h00,
        op_sub   = 6'h01,
        op_and   = 6'h02,
        op_or    = 6'h03,
        op_xor   = 6'h04,
        op_not   = 6'h05,
        op_shl   = 6'h06,
        op_shr   = 6'h07,
        op_cmp   = 6'h0B,                   // 0x08..0x0A left as no-ops
        op_sar   = 6'h0C,
        op_addi  = 6'h0D,
        op_subi  = 6'h0E,
        op_cmpi  = 6'h0F,
        op_load  = 6'h10,
        op_store = 6'h11,
        op_loadi = 6'h12,
        op_jmp   = 6'h20,
        op_jz    = 6'h21,
        op_jnz   = 6'h22,
        op_jc    = 6'h23,
        op_jnc   = 6'h24,
        op_jlt   = 6'h25,
        op_jge   = 6'h26,
        op_jle   = 6'h27,
        op_seteq = 6'h30,
        op_setne = 6'h31,
        op_setlt = 6'h32,
        op_setge = 6'h33,
        op_setle = 6'h34,
        op_setgt = 6'h35,
        op_halt  = 6'h3E
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_not, alu_shl, alu_shr, alu_sar, alu_cmp
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_memory    = 3'd3,
        st_writeback = 3'd4
    } cpu_state_t;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            opcode_t               opcode;
            logic [1:0]            mode;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rs1;
            logic [reg_addr_w-1:0] rs2;
            logic [8:0]            unused;
        } r_fmt;
        struct packed {
            opcode_t               opcode;
            logic [1:0]            mode;
            logic [reg_addr_w-1:0] rd;
            logic [18:0]           value;   // Absolute address or LOADI value
        } a_fmt;
        struct packed {
            opcode_t               opcode;
            logic [1:0]            mode;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rs1;
            logic [1:0]            spare;
            logic [11:0]           imm;     // Signed
        } i_fmt;
    } instr_t;

endpackage

// ==== rtl/alu.sv ====
/*
 * Combinational ALU
 *   Ten functions on two words
 *   C, Z, N and V flags in the low nibble of the flags byte
 */
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         op,
    output logic [xlen-1:0] result,
    output logic [7:0]      flags
);

    logic [xlen:0] sum_ext;                 // Carry in the top bit
    logic [xlen:0] diff_ext;                // a + ~b + 1
    logic [4:0]    shamt;
    logic          carry;
    logic          ovf;

    assign shamt    = b[4:0];               // Shifts only look at 5 bits
    assign sum_ext  = {1'b0, a} + {1'b0, b};
    assign diff_ext = {1'b0, a} + {1'b0, ~b} + 1'b1;

    always_comb begin
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (op)
            alu_add: begin
                result = sum_ext[xlen-1:0];
                carry  = sum_ext[xlen];
                ovf    = (a[xlen-1] == b[xlen-1]) && (result[xlen-1] != a[xlen-1]);
            end
            alu_sub, alu_cmp: begin         // CMP keeps the difference for the flags
                result = diff_ext[xlen-1:0];
                carry  = diff_ext[xlen];
                ovf    = (a[xlen-1] != b[xlen-1]) && (result[xlen-1] != a[xlen-1]);
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_not: result = ~a;
            alu_shl: result = a << shamt;
            alu_shr: result = a >> shamt;
            alu_sar: result = $unsigned($signed(a) >>> shamt);
            default: result = '0;
        endcase
    end

    // Flags byte
    always_comb begin
        flags         = 8'h00;
        flags[flag_c] = carry;
        flags[flag_z] = (result == '0);
        flags[flag_n] = result[xlen-1];
        flags[flag_v] = ovf;
    end

endmodule

// ==== rtl/register_file.sv ====
/*
 * General purpose register file
 *   Two asynchronous read ports, one clocked write port
 */
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] addr_a,
    input  logic [reg_addr_w-1:0] addr_b,
    input  logic [reg_addr_w-1:0] addr_w,
    input  logic [xlen-1:0]       data_w,
    input  logic                  we,
    output logic [xlen-1:0]       data_a,
    output logic [xlen-1:0]       data_b
);

    logic [xlen-1:0] regs [reg_count];

    assign data_a = regs[addr_a];           // Combinational reads
    assign data_b = regs[addr_b];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[addr_w] <= data_w;
        end
    end

endmodule

// ==== core/decoder.sv ====
/*
 * Instruction decoder
 *   Register addresses and immediate selection
 *   ALU function mapping and instruction class strobes
 *   Branch and set conditions from the flags register
 *   Register write enable in writeback
 */
`timescale 1ns/10ps

module decoder import cpu_pkg::*; (
    input  cpu_state_t            state,
    input  instr_t                instr,
    input  logic [7:0]            flags,
    output logic [reg_addr_w-1:0] addr_a,
    output logic [reg_addr_w-1:0] addr_b,
    output logic [reg_addr_w-1:0] addr_w,
    output logic [xlen-1:0]       imm,
    output alu_op_t               alu_op,
    output logic                  use_imm,
    output logic                  is_alu,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_loadi,
    output logic                  is_set,
    output logic                  is_branch,
    output logic                  is_halt,
    output logic                  store_direct,
    output logic                  branch_taken,
    output logic                  set_value,
    output logic                  reg_we
);

    opcode_t         opcode;
    logic [xlen-1:0] imm_abs;
    logic [xlen-1:0] imm_sext;
    logic            is_cmp;
    logic            fc;
    logic            fz;
    logic            fn;

    assign opcode   = instr.r_fmt.opcode;
    assign imm_abs  = {13'h0000, instr.a_fmt.value};                  // Zero extended
    assign imm_sext = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

    assign fc = flags[flag_c];
    assign fz = flags[flag_z];
    assign fn = flags[flag_n];

    // Class strobes
    assign is_load   = (opcode == op_load);
    assign is_store  = (opcode == op_store);
    assign is_loadi  = (opcode == op_loadi);
    assign is_halt   = (opcode == op_halt);
    assign is_branch = (opcode inside {[op_jmp:op_jle]});
    assign is_set    = (opcode inside {[op_seteq:op_setgt]});
    assign is_cmp    = (opcode == op_cmp) || (opcode == op_cmpi);

    assign store_direct = is_store && (instr.i_fmt.mode == 2'b00);   // Mode 00 is absolute

    // STORE reads its data from rd and its base from rs1
    assign addr_a = is_store ? instr.r_fmt.rd : instr.i_fmt.rs1;
    assign addr_b = (is_store && !store_direct) ? instr.i_fmt.rs1 : instr.r_fmt.rs2;
    assign addr_w = instr.r_fmt.rd;

    assign imm = (is_load || is_loadi || store_direct) ? imm_abs : imm_sext;

    // ------------------------------------------------------------------------
    // ALU function map
    // ------------------------------------------------------------------------
    always_comb begin
        is_alu  = 1'b1;
        use_imm = 1'b0;
        alu_op  = alu_add;
        case (opcode)
            op_add:  alu_op = alu_add;
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_xor:  alu_op = alu_xor;
            op_not:  alu_op = alu_not;
            op_shl:  alu_op = alu_shl;
            op_shr:  alu_op = alu_shr;
            op_sar:  alu_op = alu_sar;
            op_cmp:  alu_op = alu_cmp;
            op_addi: begin
                alu_op  = alu_add;
                use_imm = 1'b1;
            end
            op_subi: begin
                alu_op  = alu_sub;
                use_imm = 1'b1;
            end
            op_cmpi: begin
                alu_op  = alu_cmp;
                use_imm = 1'b1;
            end
            default: is_alu = 1'b0;         // MUL, DIV, MOD land here as no-ops
        endcase
    end

    // Conditions from the stored flags
    always_comb begin
        case (opcode)
            op_jmp:  branch_taken = 1'b1;
            op_jz:   branch_taken = fz;
            op_jnz:  branch_taken = !fz;
            op_jc:   branch_taken = fc;
            op_jnc:  branch_taken = !fc;
            op_jlt:  branch_taken = fn;
            op_jge:  branch_taken = !fn;
            op_jle:  branch_taken = fz || fn;
            default: branch_taken = 1'b0;
        endcase
        case (opcode)
            op_seteq: set_value = fz;
            op_setne: set_value = !fz;
            op_setlt: set_value = fn;
            op_setge: set_value = !fn;
            op_setle: set_value = fn || fz;
            op_setgt: set_value = !fn && !fz;
            default:  set_value = 1'b0;
        endcase
    end

    assign reg_we = (state == st_writeback) &&
                    ((is_alu && !is_cmp) || is_set || is_load || is_loadi);

endmodule

// ==== core/sequencer.sv ====
/*
 * Multicycle sequencer
 *   Fetch, decode, execute, memory and writeback FSM
 *   PC, instruction, result, load data, flag and halt registers
 *   Memory bus drive and writeback value select
 */
`timescale 1ns/10ps

module sequencer import cpu_pkg::*; #(
    parameter logic [xlen-1:0] RESET_PC = reset_pc_default
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_ready,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            is_alu,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            is_loadi,
    input  logic            is_set,
    input  logic            is_branch,
    input  logic            is_halt,
    input  logic            store_direct,
    input  logic            branch_taken,
    input  logic            set_value,
    input  logic            use_imm,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_result,
    input  logic [7:0]      alu_flags,
    input  logic [xlen-1:0] reg_data_a,
    input  logic [xlen-1:0] reg_data_b,
    output cpu_state_t      state,
    output instr_t          instr,
    output logic [7:0]      flags,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_read,
    output logic            mem_write,
    output logic [xlen-1:0] reg_wdata,
    output logic [xlen-1:0] alu_b,
    output logic            halted
);

    cpu_state_t      next_state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result_q;              // ALU result held for writeback
    logic [xlen-1:0] load_q;
    logic [xlen-1:0] branch_target;

    // PC already points past the branch
    assign branch_target = pc + {imm[xlen-3:0], 2'b00};

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_comb begin
        case (state)
            st_fetch:     next_state = st_decode;
            st_decode:    next_state = st_execute;
            st_execute:   next_state = (is_load || is_store) ? st_memory : st_writeback;
            st_memory:    next_state = st_writeback;
            st_writeback: next_state = halted ? st_writeback : st_fetch;  // Parked after HALT
            default:      next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_fetch;
            pc     <= RESET_PC;
            instr  <= '0;
            flags  <= 8'h00;
            halted <= 1'b0;
        end else if (mem_ready) begin       // Low ready freezes everything
            state <= next_state;
            case (state)
                st_fetch: begin
                    instr <= mem_rdata;
                    pc    <= pc + 32'd4;
                end
                st_execute: begin
                    if (is_alu) begin
                        flags <= alu_flags;
                    end
                    if (is_branch && branch_taken) begin
                        pc <= branch_target;
                    end
                    if (is_halt) begin
                        halted <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (mem_ready) begin
            if (state == st_execute) begin
                result_q <= alu_result;
            end
            if (state == st_memory && is_load) begin
                load_q <= mem_rdata;        // Read data valid with ready
            end
        end
    end

    // ------------------------------------------------------------------------
    // Memory bus and datapath selects
    // ------------------------------------------------------------------------
    always_comb begin
        if (state == st_memory && is_store && !store_direct) begin
            mem_addr = reg_data_b + imm;    // Base plus signed offset
        end else if (state == st_memory) begin
            mem_addr = imm;                 // Absolute 19-bit address
        end else begin
            mem_addr = pc;
        end
    end

    assign mem_wdata = reg_data_a;          // rd value for STORE
    assign mem_read  = (state == st_fetch) || (state == st_memory && is_load);
    assign mem_write = (state == st_memory) && is_store;

    assign alu_b = use_imm ? imm : reg_data_b;

    always_comb begin
        if (is_load) begin
            reg_wdata = load_q;
        end else if (is_loadi) begin
            reg_wdata = imm;
        end else if (is_set) begin
            reg_wdata = {{(xlen-1){1'b0}}, set_value};
        end else begin
            reg_wdata = result_q;
        end
    end

endmodule

// ==== core/cpu_core.sv ====
/*
 * Processor top level
 *   Sequencer, decoder, ALU and register file with their wiring
 */
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; #(
    parameter logic [xlen-1:0] RESET_PC = reset_pc_default
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] mem_addr,
    input  logic [xlen-1:0] mem_rdata,
    output logic [xlen-1:0] mem_wdata,
    output logic            mem_read,
    output logic            mem_write,
    input  logic            mem_ready,
    output logic            halted,
    output logic [7:0]      cpu_flags
);

    cpu_state_t            state;
    instr_t                instr;
    logic [reg_addr_w-1:0] addr_a;
    logic [reg_addr_w-1:0] addr_b;
    logic [reg_addr_w-1:0] addr_w;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    logic                  use_imm;
    logic                  is_alu;
    logic                  is_load;
    logic                  is_store;
    logic                  is_loadi;
    logic                  is_set;
    logic                  is_branch;
    logic                  is_halt;
    logic                  store_direct;
    logic                  branch_taken;
    logic                  set_value;
    logic                  reg_we;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [7:0]            alu_flags;
    logic [xlen-1:0]       reg_data_a;
    logic [xlen-1:0]       reg_data_b;
    logic [xlen-1:0]       reg_wdata;

    sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .is_alu       (is_alu),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_loadi     (is_loadi),
        .is_set       (is_set),
        .is_branch    (is_branch),
        .is_halt      (is_halt),
        .store_direct (store_direct),
        .branch_taken (branch_taken),
        .set_value    (set_value),
        .use_imm      (use_imm),
        .imm          (imm),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .reg_data_a   (reg_data_a),
        .reg_data_b   (reg_data_b),
        .state        (state),
        .instr        (instr),
        .flags        (cpu_flags),      // Flags register is also the status output
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .reg_wdata    (reg_wdata),
        .alu_b        (alu_b),
        .halted       (halted)
    );

    decoder u_decoder (
        .state        (state),
        .instr        (instr),
        .flags        (cpu_flags),
        .addr_a       (addr_a),
        .addr_b       (addr_b),
        .addr_w       (addr_w),
        .imm          (imm),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .is_alu       (is_alu),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_loadi     (is_loadi),
        .is_set       (is_set),
        .is_branch    (is_branch),
        .is_halt      (is_halt),
        .store_direct (store_direct),
        .branch_taken (branch_taken),
        .set_value    (set_value),
        .reg_we       (reg_we)
    );

    alu u_alu (
        .a      (reg_data_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    register_file u_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr_a (addr_a),
        .addr_b (addr_b),
        .addr_w (addr_w),
        .data_w (reg_wdata),
        .we     (reg_we),
        .data_a (reg_data_a),
        .data_b (reg_data_b)
    );

endmodule

// ==== tests/mem_model.sv ====
/*
 * Testbench memory for the core
 *   Word array with combinational read data during reads
 *   Ready level, optionally dropped at random
 *   Backdoor clear, word load and readback
 */
`timescale 1ns/10ps

module mem_model (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        read,
    input  logic        write,
    input  logic        stall_en,
    output logic [31:0] rdata,
    output logic        ready
);

    logic [31:0] mem [65536];               // 256 KiB as 32-bit words
    integer      seed;

    initial begin
        seed  = 54832;
        ready = 1'b1;
    end

    // Valid in the same cycle, zero outside reads
    assign rdata = read ? mem[addr[17:2]] : 32'h0000_0000;

    // Ready drops about one cycle in four when stalls are on
    always @(posedge clk) begin
        if (stall_en) begin
            ready <= (($random(seed) & 3) != 0);
        end else begin
            ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (write && ready) begin
            mem[addr[17:2]] <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Backdoor access
    // ------------------------------------------------------------------------
    task automatic clear_all();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 32'h0000_0000;
        end
    endtask

    task automatic write_word(input logic [31:0] waddr, input logic [31:0] wval);
        mem[waddr[17:2]] = wval;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] raddr);
        return mem[raddr[17:2]];
    endfunction

endmodule

// ==== tests/tb_cpu_core.sv ====
/*
 * Testbench for the multicycle core
 *   Test table built from small programs, one result word or bit mask each
 *   Clock, reset, program load, halt wait and readback per test
 *   Halt monitor and cycle timeout
 */
`timescale 1ns/10ps

module tb_cpu_core import cpu_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        stall_en;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;
    logic        mem_ready;
    logic        halted;
    logic [7:0]  cpu_flags;

    // Test table
    string       names     [16];
    logic [31:0] prog      [16][16];
    int          plen      [16];
    logic [31:0] res_addr  [16];
    int          nwords    [16];            // Above 1, bit k is word k
    logic [31:0] exp_word  [16];
    logic [7:0]  exp_flags [16];
    logic        stall     [16];
    int          n_tests;
    int          cycles;
    int          limit;
    logic        watch;                     // Halt monitor on

    cpu_core #(.RESET_PC(32'h0000_8000)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_ready (mem_ready),
        .halted    (halted),
        .cpu_flags (cpu_flags)
    );

    mem_model u_mem (
        .clk      (clk),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .read     (mem_read),
        .write    (mem_write),
        .stall_en (stall_en),
        .rdata    (mem_rdata),
        .ready    (mem_ready)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_r(logic [5:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2);
        return {op, 2'b00, rd, rs1, rs2, 9'h000};
    endfunction

    function automatic logic [31:0] enc_a(logic [5:0] op, logic [4:0] rd, logic [18:0] val);
        return {op, 2'b00, rd, val};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [1:0] mode, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {op, mode, rd, rs1, 2'b00, imm};
    endfunction

    task automatic open_test(string name, logic [31:0] addr, int words, logic [31:0] word,
                             logic [7:0] flags, logic stalls);
        names[n_tests]     = name;
        res_addr[n_tests]  = addr;
        nwords[n_tests]    = words;
        exp_word[n_tests]  = word;
        exp_flags[n_tests] = flags;
        stall[n_tests]     = stalls;
        plen[n_tests]      = 0;
    endtask

    task automatic put(logic [31:0] w);
        prog[n_tests][plen[n_tests]] = w;
        plen[n_tests]++;
    endtask

    task automatic close_test();
        put(enc_a(op_halt, 5'd0, 19'd0));
        for (int k = plen[n_tests]; k < 16; k++) begin
            prog[n_tests][k] = enc_a(op_halt, 5'd0, 19'd0);   // Padding
        end
        n_tests++;
    endtask

    // 100 + 23, 23 - 100, then their sum
    task automatic add_sub_test(string name, logic stalls);
        open_test(name, 32'h100, 1, 32'd46, 8'h01, stalls);
        put(enc_a(op_loadi, 5'd1, 19'd100));
        put(enc_a(op_loadi, 5'd2, 19'd23));
        put(enc_r(op_add, 5'd3, 5'd1, 5'd2));
        put(enc_r(op_sub, 5'd4, 5'd2, 5'd1));
        put(enc_r(op_add, 5'd5, 5'd3, 5'd4));    // Wraps with a carry out
        put(enc_a(op_store, 5'd5, 19'h100));
        close_test();
    endtask

    // Six set results stored as words, SETEQ first
    task automatic set_test(string name, logic [18:0] a, logic [18:0] b, logic imm_form,
                            logic [31:0] mask, logic [7:0] flags);
        open_test(name, 32'h200, 6, mask, flags, 1'b0);
        put(enc_a(op_loadi, 5'd1, a));
        if (imm_form) begin
            put(enc_i(op_cmpi, 2'b00, 5'd0, 5'd1, b[11:0]));
        end else begin
            put(enc_a(op_loadi, 5'd2, b));
            put(enc_r(op_cmp, 5'd0, 5'd1, 5'd2));
        end
        for (int k = 0; k < 6; k++) begin
            put(enc_a(6'(op_seteq + k), 5'(3 + k), 19'd0));
        end
        for (int k = 0; k < 6; k++) begin
            put(enc_a(op_store, 5'(3 + k), 19'(32'h200 + 4 * k)));
        end
        close_test();
    endtask

    // Each branch skips one marker LOADI when taken
    task automatic branch_test(string name, logic [18:0] a, logic [18:0] b, logic [5:0] j0,
                               logic [5:0] j1, logic [5:0] j2, logic [5:0] j3,
                               logic [31:0] mask, logic [7:0] flags);
        logic [5:0] ops [4];
        ops = '{j0, j1, j2, j3};
        open_test(name, 32'h200, 4, mask, flags, 1'b0);
        put(enc_a(op_loadi, 5'd1, a));
        put(enc_a(op_loadi, 5'd2, b));
        put(enc_r(op_cmp, 5'd0, 5'd1, 5'd2));
        for (int k = 0; k < 4; k++) begin
            put(enc_i(ops[k], 2'b00, 5'd0, 5'd0, 12'd1));
            put(enc_a(op_loadi, 5'(10 + k), 19'd1));
        end
        for (int k = 0; k < 4; k++) begin
            put(enc_a(op_store, 5'(10 + k), 19'(32'h200 + 4 * k)));
        end
        close_test();
    endtask

    task automatic build_table();
        n_tests = 0;
        add_sub_test("add_sub", 1'b0);
        open_test("logic_ops", 32'h100, 1, 32'hFFFF_ED3B, 8'h04, 1'b0);
        put(enc_a(op_loadi, 5'd1, 19'h1234));
        put(enc_a(op_loadi, 5'd2, 19'h00F0));
        put(enc_r(op_and, 5'd3, 5'd1, 5'd2));    // 0x0030
        put(enc_r(op_or, 5'd4, 5'd1, 5'd2));     // 0x12F4
        put(enc_r(op_xor, 5'd5, 5'd4, 5'd3));    // 0x12C4
        put(enc_r(op_not, 5'd6, 5'd5, 5'd0));
        put(enc_a(op_store, 5'd6, 19'h100));
        close_test();
        open_test("shift_imm", 32'h104, 1, 32'h0000_00C0, 8'h01, 1'b0);
        put(enc_a(op_loadi, 5'd1, 19'h00F0));
        put(enc_r(op_not, 5'd2, 5'd1, 5'd0));    // 0xFFFFFF0F
        put(enc_a(op_loadi, 5'd3, 19'd36));      // Low 5 bits give 4
        put(enc_r(op_sar, 5'd4, 5'd2, 5'd3));    // 0xFFFFFFF0
        put(enc_r(op_shr, 5'd5, 5'd2, 5'd3));    // 0x0FFFFFF0
        put(enc_r(op_shl, 5'd6, 5'd5, 5'd3));    // 0xFFFFFF00
        put(enc_r(op_xor, 5'd7, 5'd4, 5'd6));    // 0xF0
        put(enc_i(op_addi, 2'b00, 5'd8, 5'd7, 12'hFF0));
        put(enc_i(op_subi, 2'b00, 5'd9, 5'd8, 12'h020));
        put(enc_a(op_store, 5'd9, 19'h104));
        close_test();
        set_test("set_equal", 19'd5, 19'd5, 1'b0, 32'h19, 8'h03);
        set_test("set_smaller", 19'd3, 19'd9, 1'b0, 32'h16, 8'h04);
        set_test("set_larger_imm", 19'd9, 19'd3, 1'b1, 32'h2A, 8'h01);
        branch_test("branch_zc_eq", 19'd5, 19'd5, op_jz, op_jnz, op_jc, op_jnc, 32'hA, 8'h03);
        branch_test("branch_sign_eq", 19'd5, 19'd5, op_jlt, op_jge, op_jle, op_jmp, 32'h1,
                    8'h03);
        branch_test("branch_zc_lt", 19'd3, 19'd9, op_jz, op_jnz, op_jc, op_jnc, 32'h5, 8'h04);
        branch_test("branch_sign_lt", 19'd3, 19'd9, op_jlt, op_jge, op_jle, op_jmp, 32'h2,
                    8'h04);
        branch_test("branch_sign_gt", 19'd9, 19'd3, op_jlt, op_jge, op_jle, op_jmp, 32'h5,
                    8'h01);
        open_test("load_store_direct", 32'h400, 1, 32'hCAFE_0123, 8'h00, 1'b0);
        put(enc_a(op_load, 5'd1, 19'h300));      // Preloaded word
        put(enc_a(op_store, 5'd1, 19'h400));
        close_test();
        open_test("store_offset", 32'h418, 1, 32'hCAFE_0123, 8'h00, 1'b0);
        put(enc_a(op_load, 5'd1, 19'h300));
        put(enc_a(op_loadi, 5'd3, 19'h420));
        put(enc_i(op_store, 2'b01, 5'd1, 5'd3, 12'hFF8));   // 0x420 - 8
        close_test();
        add_sub_test("add_sub_stalled", 1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Checks and run control
    // ------------------------------------------------------------------------
    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic run_test(int t);
        logic [31:0] got;
        logic [31:0] w;
        @(posedge clk);
        watch = 1'b0;
        rst_n    <= 1'b0;
        stall_en <= stall[t];
        u_mem.clear_all();
        for (int k = 0; k < 16; k++) begin
            u_mem.write_word(32'h8000 + 32'(4 * k), prog[t][k]);
        end
        u_mem.write_word(32'h300, 32'hCAFE_0123);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        watch = 1'b1;                        // Halt must hold with no writes
        repeat (8) @(posedge clk);
        watch = 1'b0;
        got = 32'h0;
        for (int k = 0; k < nwords[t]; k++) begin
            w = u_mem.read_word(res_addr[t] + 32'(4 * k));
            if (nwords[t] == 1) begin
                got = w;
            end else begin
                got = got | (w << k);
            end
        end
        check(names[t], exp_word[t], got);
        check({names[t], " flags"}, {24'h0, exp_flags[t]}, {24'h0, cpu_flags});
    endtask

    always @(negedge clk) begin
        if (watch && halted !== 1'b1) begin
            $display("Core left the halted state before reset");
            $display("Some tests failed");
            $fatal(1);
        end else if (watch && mem_write !== 1'b0) begin
            $display("Core wrote memory after it halted");
            $display("Some tests failed");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the core never halted", cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        int words;
        clk      = 1'b0;
        rst_n    = 1'b0;
        stall_en = 1'b0;
        watch    = 1'b0;
        cycles   = 0;
        limit    = 1000000;
        build_table();
        words = 0;
        for (int t = 0; t < n_tests; t++) begin
            words += plen[t];
        end
        limit = words * 5 * 4 + n_tests * (16 + 10);    // Reset and halt hold per test
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
common/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
core/decoder.sv
core/sequencer.sv
core/cpu_core.sv
tests/mem_model.sv
tests/tb_cpu_core.sv

// ==== Makefile ====
# Verilator build and run for the multicycle core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
